/* build.f */
common/sifh_pkg.sv
hdl/tdc_binner.sv
his_builder/his_bank_ram.sv
his_builder/his_builder.sv
hdl/his_readout.sv
hdl/sifh_top.sv
dv/clk_gen.sv
dv/his_chk.sv
dv/tb_sifh.sv

/* common/sifh_pkg.sv */
package sifh_pkg;

    // raw tdc code from the time converter
    localparam int TDC_W = 8;

    // first accepted code, laser-sync offset
    localparam int GATE_START = 8;

    // codes per bin as a power of two
    localparam int BIN_SHIFT = 3;

    // bins per pixel
    localparam int NB = 16;
    localparam int BIN_W = 4;

    // pixels per frame
    localparam int NPIX = 4;
    localparam int PIX_W = 2;

    // accepted events per pixel in one acquisition
    localparam int DATA_NUM = 16;
    localparam int EVT_W = 4;

    // acquisitions summed into one frame
    localparam int ACQ_NUM = 2;
    localparam int ACQ_W = 1;

    // max count is DATA_NUM * ACQ_NUM = 32
    localparam int COUNT_W = 9;

    // memory address is {pixel, bin}
    localparam int ADDR_W = 6;

    localparam int FRAME_W = 15;

    // first code past the window (136)
    localparam int GATE_END = GATE_START + (NB << BIN_SHIFT);

    // bins in one bank, also bin words per readout
    localparam int NWORDS = NPIX * NB;

    // two banks in the ping-pong memory
    localparam int MEM_DEPTH = 2 * NWORDS;

    // one gated hit, already binned
    typedef struct packed {
        logic             valid;
        logic [BIN_W-1:0] bin;
    } bin_event_t;

    // increment request into the histogram memory
    typedef struct packed {
        logic              inc;
        logic              bank;
        logic [ADDR_W-1:0] addr;
    } bank_wr_t;

    // header word, top bit set
    typedef struct packed {
        logic               is_hdr;
        logic [FRAME_W-1:0] frame;
    } hdr_fields_t;

    // bin word, top bit clear
    typedef struct packed {
        logic               is_hdr;
        logic [PIX_W-1:0]   pixel;
        logic [BIN_W-1:0]   bin;
        logic [COUNT_W-1:0] count;
    } bin_fields_t;

    // one 16-bit stream word, is_hdr selects the view
    typedef union packed {
        hdr_fields_t hdr;
        bin_fields_t entry;
    } readout_word_u;

endpackage

/* dv/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen (
    output logic clk,
    output logic res
);
    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset low for 8 rising edges, released between edges
    initial begin
        res = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
    end

endmodule

/* dv/his_chk.sv */
`timescale 1ns/10ps

module his_chk (
    input logic               clk,
    input logic               res,
    input logic               frame_done,
    input sifh_pkg::bank_wr_t wr,
    input logic               rd_en,
    input logic               rd_bank
);

    // next frame may only close once the last bank is fully scanned
    a_no_overrun: assert property (@(posedge clk) disable iff (!res)
        frame_done |-> !rd_en)
        else $error("frame closed while the previous readout was still running");

    // increments and read-and-clear never share a bank
    a_bank_split: assert property (@(posedge clk) disable iff (!res)
        (rd_en && wr.inc) |-> (wr.bank != rd_bank))
        else $error("increment went to the bank under readout");

endmodule

/* dv/tb_sifh.sv */
`timescale 1ns/10ps

module tb_sifh;
    import sifh_pkg::*;

    localparam int N_FRAMES = 7;
    localparam int MAX_FRAMES = 8;
    localparam int STREAM_LEN = NWORDS + 1;
    // hit plus up to 3 idle cycles
    localparam int MAX_GAP = 4;
    localparam int FRAME_EVTS = DATA_NUM * NPIX * ACQ_NUM;
    localparam int WATCHDOG_NS = (10 + N_FRAMES * (FRAME_EVTS * MAX_GAP + 70)) * 8;

    logic                clk;
    logic                res;
    logic                hit;
    logic [TDC_W-1:0]    tdc_code;
    logic                frame_done;
    logic                out_valid;
    readout_word_u       out_word;

    // reference model state
    int    exp_hist [MAX_FRAMES][NWORDS];
    int    close_cyc [MAX_FRAMES];
    string frame_test [MAX_FRAMES];
    int    ref_evt;
    int    ref_pix;
    int    ref_acq;
    int    frames_built;
    int    frames_checked;
    int    pulse_count;
    int    cyc;
    string cur_test;
    logic [16:0] lfsr_state;

    clk_gen clk0 (
        .clk (clk),
        .res (res)
    );

    sifh_top dut0 (
        .clk        (clk),
        .res        (res),
        .hit        (hit),
        .tdc_code   (tdc_code),
        .frame_done (frame_done),
        .out_valid  (out_valid),
        .out_word   (out_word)
    );

    bind his_builder his_chk chk0 (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .wr         (wr),
        .rd_en      (rd_en),
        .rd_bank    (rd_bank)
    );

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input readout_word_u exp_w,
                              input readout_word_u act_w);
        if (act_w !== exp_w) begin
            report_failure($sformatf("** Error %s: expected %h actual %h", name, exp_w, act_w));
        end
    endtask

    task automatic check_pulse(input string name, input int exp_n, input int act_n);
        if (act_n != exp_n) begin
            report_failure($sformatf("** Error %s: expected %0d actual %0d", name, exp_n, act_n));
        end
    endtask

    task automatic check_latency(input string name, input int exp_n, input int act_n);
        if (act_n != exp_n) begin
            report_failure($sformatf("** Error %s: expected %0d actual %0d", name, exp_n, act_n));
        end
    endtask

    // fibonacci lfsr with taps x^17 and x^14, stepped once per bit
    function automatic int take_bits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[16] ^ lfsr_state[13];
            lfsr_state = {lfsr_state[15:0], fb};
            v = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    // gate and bin one driven hit, then step the nested counters
    function automatic void model_hit(input logic [TDC_W-1:0] code);
        int c;
        int bin;
        int a;
        c = int'(code);
        // window is [8, 8 + 16 bins * 8 codes)
        if (c >= GATE_START && c < GATE_START + NB * (1 << BIN_SHIFT)) begin
            bin = (c - GATE_START) / (1 << BIN_SHIFT);
            a = ref_pix * NB + bin;
            exp_hist[frames_built][a] = exp_hist[frames_built][a] + 1;
            ref_evt++;
            if (ref_evt == DATA_NUM) begin
                ref_evt = 0;
                ref_pix++;
                if (ref_pix == NPIX) begin
                    ref_pix = 0;
                    ref_acq++;
                    if (ref_acq == ACQ_NUM) begin
                        // this hit closes the frame
                        ref_acq = 0;
                        frame_test[frames_built] = cur_test;
                        close_cyc[frames_built] = cyc;
                        frames_built++;
                    end
                end
            end
        end
    endfunction

    // word w of the stream for frame f with the header first
    function automatic readout_word_u expected_word(input int f, input int w);
        readout_word_u word;
        int            idx;
        word = '0;
        if (w == 0) begin
            word.hdr.is_hdr = 1'b1;
            word.hdr.frame  = FRAME_W'(f);
        end else begin
            idx = w - 1;
            word.entry.is_hdr = 1'b0;
            word.entry.pixel  = PIX_W'(idx / NB);
            word.entry.bin    = BIN_W'(idx % NB);
            word.entry.count  = COUNT_W'(exp_hist[f][idx]);
        end
        return word;
    endfunction

    task automatic send_hit(input logic [TDC_W-1:0] code, input int idle);
        @(negedge clk);
        hit      = 1'b1;
        tdc_code = code;
        model_hit(code);
        repeat (idle) begin
            @(negedge clk);
            hit = 1'b0;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            hit = 1'b0;
        end
    endtask

    // every in-window code once with edge rejects mixed in
    task automatic run_gating_frame();
        for (int c = GATE_START; c < GATE_START + NB * 8; c++) begin
            if (c == 8) begin
                send_hit(TDC_W'(7), 0);
            end
            if (c == 72) begin
                send_hit(TDC_W'(136), 0);
                send_hit(TDC_W'(0), 0);
            end
            if (c == 135) begin
                send_hit(TDC_W'(255), 0);
            end
            send_hit(TDC_W'(c), 0);
        end
    endtask

    // hit every cycle on one code until the frame closes
    task automatic run_same_bin_frame(input int code);
        int start;
        start = frames_built;
        while (frames_built == start) begin
            send_hit(TDC_W'(code), 0);
        end
    endtask

    task automatic run_random_frame();
        int start;
        int code;
        int gap;
        start = frames_built;
        while (frames_built == start) begin
            code = GATE_START + take_bits(7);
            gap = take_bits(2);
            send_hit(TDC_W'(code), gap);
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // stimulus
    initial begin
        hit = 1'b0;
        tdc_code = '0;
        lfsr_state = 17'd93001;
        ref_evt = 0;
        ref_pix = 0;
        ref_acq = 0;
        frames_built = 0;
        cur_test = "init";
        for (int f = 0; f < MAX_FRAMES; f++) begin
            close_cyc[f] = 0;
            for (int i = 0; i < NWORDS; i++) begin
                exp_hist[f][i] = 0;
            end
        end
        @(posedge res);
        idle_cycles(2);
        cur_test = "gating";
        run_gating_frame();
        // code 77 lands in bin 8
        cur_test = "same_bin";
        run_same_bin_frame(77);
        cur_test = "random";
        repeat (3) run_random_frame();
        // both banks reused after a full-scale frame
        cur_test = "clear_swap";
        run_same_bin_frame(135);
        run_same_bin_frame(8);
        idle_cycles(1);
        while (frames_checked < N_FRAMES) begin
            @(negedge clk);
        end
        // room for a stray extra word or pulse
        idle_cycles(8);
        check_pulse("frame_done count", N_FRAMES, pulse_count);
        $display("All tests passed");
        $finish;
    end

    // compare process samples on the falling edge
    initial begin
        int   widx;
        logic prev_valid;
        widx = 0;
        prev_valid = 1'b0;
        frames_checked = 0;
        pulse_count = 0;
        forever begin
            @(negedge clk);
            if (frame_done === 1'b1) begin
                pulse_count++;
            end
            if (out_valid === 1'b1) begin
                if (!prev_valid) begin
                    widx = 0;
                    if (frames_checked >= frames_built) begin
                        report_failure("readout stream started with no completed frame");
                    end
                    // header 4 cycles after the closing hit
                    check_latency($sformatf("%s frame %0d latency", frame_test[frames_checked],
                                  frames_checked), 4, cyc - close_cyc[frames_checked]);
                end
                if (widx >= STREAM_LEN) begin
                    report_failure("readout stream is longer than 65 words");
                end
                check_word($sformatf("%s frame %0d word %0d", frame_test[frames_checked],
                           frames_checked, widx), expected_word(frames_checked, widx), out_word);
                widx++;
                if (widx == STREAM_LEN) begin
                    frames_checked++;
                end
            end else if (prev_valid && widx < STREAM_LEN) begin
                report_failure("readout stream stopped before all 65 words were sent");
            end
            prev_valid = (out_valid === 1'b1);
        end
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before all frames were read out");
    end

endmodule

/* hdl/his_readout.sv */
`timescale 1ns/10ps

module his_readout (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        frame_done,
    input  logic                        done_bank,
    input  logic [sifh_pkg::FRAME_W-1:0] frame,
    output logic                        rd_en,
    output logic                        rd_bank,
    output logic [sifh_pkg::ADDR_W-1:0]  rd_addr,
    input  logic [sifh_pkg::COUNT_W-1:0] rd_count,
    output logic                        out_valid,
    output sifh_pkg::readout_word_u     out_word
);
    import sifh_pkg::*;

    // scan running over the finished bank
    logic              busy;
    logic [ADDR_W-1:0] scan_addr;

    // header goes out the cycle before the first count returns
    logic hdr_pend;

    // read request delayed to line up with rd_count
    logic              rd_en_d;
    logic [ADDR_W-1:0] addr_d;

    // snapshot of the finished frame
    logic               bank_q;
    logic [FRAME_W-1:0] frame_q;

    assign rd_en   = busy;
    assign rd_bank = bank_q;
    assign rd_addr = scan_addr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            busy      <= 1'b0;
            scan_addr <= '0;
            hdr_pend  <= 1'b0;
            rd_en_d   <= 1'b0;
            out_valid <= 1'b0;
            out_word  <= '0;
        end else begin
            hdr_pend <= frame_done;
            rd_en_d  <= busy;

            // one read-and-clear per cycle, pixel-major order
            if (frame_done) begin
                busy      <= 1'b1;
                scan_addr <= '0;
            end else if (busy) begin
                scan_addr <= scan_addr + 1'b1;
                if (scan_addr == ADDR_W'(NWORDS - 1)) begin
                    busy <= 1'b0;
                end
            end

            // header then 64 bins, no gaps
            out_valid <= hdr_pend || rd_en_d;
            if (hdr_pend) begin
                out_word.hdr.is_hdr <= 1'b1;
                out_word.hdr.frame  <= frame_q;
            end else if (rd_en_d) begin
                out_word.entry.is_hdr <= 1'b0;
                out_word.entry.pixel  <= addr_d[ADDR_W-1:BIN_W];
                out_word.entry.bin    <= addr_d[BIN_W-1:0];
                out_word.entry.count  <= rd_count;
            end
        end
    end

    // payload, only sampled while a readout is running
    always_ff @(posedge clk) begin
        if (frame_done) begin
            bank_q  <= done_bank;
            frame_q <= frame;
        end
        addr_d <= scan_addr;
    end

endmodule

/* hdl/sifh_top.sv */
`timescale 1ns/10ps

module sifh_top (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      hit,
    input  logic [sifh_pkg::TDC_W-1:0] tdc_code,
    output logic                      frame_done,
    output logic                      out_valid,
    output sifh_pkg::readout_word_u   out_word
);
    import sifh_pkg::*;

    // binner to builder
    bin_event_t evt;

    // builder to readout
    logic               done_bank;
    logic [FRAME_W-1:0] frame;

    // readout to memory read port
    logic               rd_en;
    logic               rd_bank;
    logic [ADDR_W-1:0]  rd_addr;
    logic [COUNT_W-1:0] rd_count;

    tdc_binner u_binner (
        .clk      (clk),
        .res      (res),
        .hit      (hit),
        .tdc_code (tdc_code),
        .evt      (evt)
    );

    // increments stay inside the builder path
    his_builder u_builder (
        .clk        (clk),
        .res        (res),
        .evt        (evt),
        .wr         (),
        .frame_done (frame_done),
        .done_bank  (done_bank),
        .frame      (frame),
        .rd_en      (rd_en),
        .rd_bank    (rd_bank),
        .rd_addr    (rd_addr),
        .rd_count   (rd_count)
    );

    his_readout u_readout (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .done_bank  (done_bank),
        .frame      (frame),
        .rd_en      (rd_en),
        .rd_bank    (rd_bank),
        .rd_addr    (rd_addr),
        .rd_count   (rd_count),
        .out_valid  (out_valid),
        .out_word   (out_word)
    );

endmodule

/* hdl/tdc_binner.sv */
`timescale 1ns/10ps

module tdc_binner (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      hit,
    input  logic [sifh_pkg::TDC_W-1:0] tdc_code,
    output sifh_pkg::bin_event_t      evt
);
    import sifh_pkg::*;

    // code relative to the window start
    logic [TDC_W-1:0] offset;

    // code inside [GATE_START, GATE_END)
    logic in_win;

    // bin index of the current code
    logic [BIN_W-1:0] bin_idx;

    assign offset = tdc_code - TDC_W'(GATE_START);

    // lower edge is inclusive, upper edge exclusive
    assign in_win = (tdc_code >= TDC_W'(GATE_START)) &&
                    (tdc_code < TDC_W'(GATE_END));

    // drop the fine bits, keep the bin bits
    assign bin_idx = offset[BIN_SHIFT +: BIN_W];

    // one registered event per accepted hit
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            evt <= '0;
        end else begin
            // rejected codes give no event at all
            evt.valid <= hit && in_win;
            evt.bin   <= bin_idx;
        end
    end

endmodule

/* his_builder/his_bank_ram.sv */
`timescale 1ns/10ps

module his_bank_ram (
    input  logic                        clk,
    input  logic                        res,
    input  sifh_pkg::bank_wr_t          wr,
    input  logic                        rd_en,
    input  logic                        rd_bank,
    input  logic [sifh_pkg::ADDR_W-1:0]  rd_addr,
    output logic [sifh_pkg::COUNT_W-1:0] rd_count
);
    import sifh_pkg::*;

    // both banks, index is {bank, pixel, bin}
    logic [COUNT_W-1:0] mem [MEM_DEPTH];

    // full indices for both ports
    logic [ADDR_W:0] wr_idx;
    logic [ADDR_W:0] rd_idx;

    // stage 1, request plus registered read of the old count
    logic               s1_inc;
    logic [ADDR_W:0]    s1_idx;
    logic [COUNT_W-1:0] s1_cnt;

    // stage 2, what was written one edge ago
    logic               s2_inc;
    logic [ADDR_W:0]    s2_idx;
    logic [COUNT_W-1:0] s2_cnt;

    logic               fwd;
    logic [COUNT_W-1:0] sum;

    assign wr_idx = {wr.bank, wr.addr};
    assign rd_idx = {rd_bank, rd_addr};

    // s1_cnt was read on the same edge s2 wrote, so it is stale on a match
    assign fwd = s2_inc && (s2_idx == s1_idx);
    assign sum = (fwd ? s2_cnt : s1_cnt) + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // whole array starts from zero
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
            s1_inc   <= 1'b0;
            s1_idx   <= '0;
            s1_cnt   <= '0;
            s2_inc   <= 1'b0;
            s2_idx   <= '0;
            s2_cnt   <= '0;
            rd_count <= '0;
        end else begin
            // stage 1 captures the request and the stored count
            s1_inc <= wr.inc;
            s1_idx <= wr_idx;
            s1_cnt <= mem[wr_idx];

            // stage 2 writes back and keeps the value for forwarding
            s2_inc <= s1_inc;
            s2_idx <= s1_idx;
            s2_cnt <= sum;
            if (s1_inc) begin
                mem[s1_idx] <= sum;
            end

            // read and clear, always the idle bank
            if (rd_en) begin
                rd_count    <= mem[rd_idx];
                mem[rd_idx] <= '0;
            end
        end
    end

endmodule

/* his_builder/his_builder.sv */
`timescale 1ns/10ps

module his_builder (
    input  logic                        clk,
    input  logic                        res,
    input  sifh_pkg::bin_event_t        evt,
    output sifh_pkg::bank_wr_t          wr,
    output logic                        frame_done,
    output logic                        done_bank,
    output logic [sifh_pkg::FRAME_W-1:0] frame,
    input  logic                        rd_en,
    input  logic                        rd_bank,
    input  logic [sifh_pkg::ADDR_W-1:0]  rd_addr,
    output logic [sifh_pkg::COUNT_W-1:0] rd_count
);
    import sifh_pkg::*;

    // nested counters, event inside pixel inside acquisition
    logic [EVT_W-1:0] evt_idx;
    logic [PIX_W-1:0] pix_idx;
    logic [ACQ_W-1:0] acq_idx;

    // active bank for increments
    logic bank;

    logic last_evt;
    logic last_pix;
    logic last_acq;
    logic frame_end;

    assign last_evt = (evt_idx == EVT_W'(DATA_NUM - 1));
    assign last_pix = (pix_idx == PIX_W'(NPIX - 1));
    assign last_acq = (acq_idx == ACQ_W'(ACQ_NUM - 1));

    // this event closes the frame
    assign frame_end = evt.valid && last_evt && last_pix && last_acq;

    // bank toggles with frame_done, so the finished one is the other bank
    assign done_bank = ~bank;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            evt_idx    <= '0;
            pix_idx    <= '0;
            acq_idx    <= '0;
            bank       <= 1'b0;
            wr         <= '0;
            frame_done <= 1'b0;
            frame      <= '0;
        end else begin
            // increment at current pixel and event bin, old bank
            wr.inc  <= evt.valid;
            wr.bank <= bank;
            wr.addr <= {pix_idx, evt.bin};

            frame_done <= frame_end;

            // readout latches the number first, then it moves on
            if (frame_done) begin
                frame <= frame + 1'b1;
            end

            if (evt.valid) begin
                if (!last_evt) begin
                    evt_idx <= evt_idx + 1'b1;
                end else begin
                    evt_idx <= '0;
                    // pixel done, step to the next one
                    if (!last_pix) begin
                        pix_idx <= pix_idx + 1'b1;
                    end else begin
                        pix_idx <= '0;
                        // all pixels seen once, next acquisition
                        if (!last_acq) begin
                            acq_idx <= acq_idx + 1'b1;
                        end else begin
                            acq_idx <= '0;
                        end
                    end
                end
            end

            // ping-pong swap at end of frame
            if (frame_end) begin
                bank <= ~bank;
            end
        end
    end

    // count memory, read port goes straight to the readout
    his_bank_ram u_ram (
        .clk      (clk),
        .res      (res),
        .wr       (wr),
        .rd_en    (rd_en),
        .rd_bank  (rd_bank),
        .rd_addr  (rd_addr),
        .rd_count (rd_count)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# compile with verilator and run, exit status is the test result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f build.f \
    --top-module tb_sifh \
    -o tb_sifh \
    && ./obj_dir/tb_sifh \
    || exit 1
